/* source/parser_cfg_pkg.sv */
package parser_cfg_pkg;

    // stream and header window
    localparam int DATA_W   = 512;
    localparam int HDR_W    = 1024;

    // action table
    localparam int ACT_W    = 16;
    localparam int NUM_ACT  = 10;
    localparam int ENTRY_W  = NUM_ACT * ACT_W;
    localparam int TBL_AW   = 4;

    // phv containers, per size class
    localparam int NUM_CONT = 8;
    localparam int C2_W     = 16;
    localparam int C4_W     = 32;
    localparam int C6_W     = 48;
    localparam int PHV_W    = NUM_CONT * (C2_W + C4_W + C6_W);

    // vlan id position in the first beat
    localparam int VLAN_LSB = 116;

    // size class codes of a parse action
    localparam logic [1:0] SZ_NONE = 2'd0;
    localparam logic [1:0] SZ_2B   = 2'd1;
    localparam logic [1:0] SZ_4B   = 2'd2;
    localparam logic [1:0] SZ_6B   = 2'd3;

endpackage

/* source/parser_ctrl_pkg.sv */
package parser_ctrl_pkg;

    // control header field positions
    localparam int FLAG_LSB   = 320;
    localparam int FLAG_W     = 16;
    localparam int MOD_ID_LSB = 368;
    localparam int MOD_ID_W   = 8;
    localparam int IDX_LSB    = 384;
    localparam int IDX_W      = 8;

    // marks a table write message
    localparam logic [FLAG_W-1:0] CTRL_FLAG = 16'hf2f1;

    typedef struct packed {
        logic [parser_cfg_pkg::DATA_W-IDX_LSB-IDX_W-1:0] rsvd3;
        logic [IDX_W-1:0]                                start_idx;
        logic [IDX_LSB-MOD_ID_LSB-MOD_ID_W-1:0]          rsvd2;
        logic [MOD_ID_W-1:0]                             mod_id;
        logic [MOD_ID_LSB-FLAG_LSB-FLAG_W-1:0]           rsvd1;
        logic [FLAG_W-1:0]                               flag;
        logic [FLAG_LSB-1:0]                             rsvd0;
    } ctrl_hdr_t;

    // header beat or table entry beat, byte 0 in the low bits
    typedef union packed {
        ctrl_hdr_t                                        hdr;
        logic [parser_cfg_pkg::DATA_W/8-1:0][7:0]         bytes;
    } ctrl_beat_u;

endpackage

/* source/pkt_hdr_capture.sv */
`timescale 1ns/1ps

module pkt_hdr_capture #(
    parameter int DATA_W   = parser_cfg_pkg::DATA_W,
    parameter int HDR_W    = parser_cfg_pkg::HDR_W,
    parameter int TBL_AW   = parser_cfg_pkg::TBL_AW,
    parameter int VLAN_LSB = parser_cfg_pkg::VLAN_LSB
) (
    input  logic              axis_clk,
    input  logic              aresetn,
    input  logic [DATA_W-1:0] s_axis_tdata_i,
    input  logic              s_axis_tvalid_i,
    input  logic              s_axis_tlast_i,
    output logic              first_beat_o,
    output logic [HDR_W-1:0]  hdr_o,
    output logic [TBL_AW-1:0] rd_addr_o
);

    logic tvalid_q;
    logic hi_pend;
    logic first_beat;

    // rising tvalid marks the first beat
    assign first_beat = s_axis_tvalid_i && !tvalid_q;

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            tvalid_q     <= 1'b0;
            first_beat_o <= 1'b0;
            hi_pend      <= 1'b0;
        end else begin
            tvalid_q     <= s_axis_tvalid_i;
            first_beat_o <= first_beat;
            if (first_beat) begin
                hi_pend <= !s_axis_tlast_i;
            end else if (s_axis_tvalid_i) begin
                hi_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        if (first_beat) begin
            hdr_o[DATA_W-1:0] <= s_axis_tdata_i;
            // table index from vlan id bits 7:4
            rd_addr_o <= s_axis_tdata_i[VLAN_LSB+4 +: TBL_AW];
        end else if (s_axis_tvalid_i && hi_pend) begin
            hdr_o[HDR_W-1 -: DATA_W] <= s_axis_tdata_i;
        end
    end

endmodule

/* source/parse_act_ram.sv */
`timescale 1ns/1ps

module parse_act_ram #(
    parameter int ENTRY_W = parser_cfg_pkg::ENTRY_W,
    parameter int TBL_AW  = parser_cfg_pkg::TBL_AW
) (
    input  logic               axis_clk,
    input  logic               wr_en_i,
    input  logic [TBL_AW-1:0]  wr_addr_i,
    input  logic [ENTRY_W-1:0] wr_data_i,
    input  logic [TBL_AW-1:0]  rd_addr_i,
    output logic [ENTRY_W-1:0] entry_o
);

    logic [ENTRY_W-1:0] mem [2**TBL_AW];

    always_ff @(posedge axis_clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
    end

    // read data one cycle after the address
    always_ff @(posedge axis_clk) begin
        entry_o <= mem[rd_addr_i];
    end

endmodule

/* source/field_extractor.sv */
`timescale 1ns/1ps

module field_extractor #(
    parameter int HDR_W = parser_cfg_pkg::HDR_W,
    parameter int ACT_W = parser_cfg_pkg::ACT_W
) (
    input  logic                             axis_clk,
    input  logic                             aresetn,
    input  logic                             fire_i,
    input  logic [HDR_W-1:0]                 hdr_i,
    input  logic [ACT_W-1:0]                 action_i,
    output logic [parser_cfg_pkg::C6_W-1:0]  field_o,
    output logic [1:0]                       size_o,
    output logic [2:0]                       cont_o
);

    localparam int FW      = parser_cfg_pkg::C6_W;
    localparam int PAD_W   = HDR_W + FW - 8;
    localparam int POS_W   = $clog2(PAD_W);

    logic [HDR_W-1:0] hdr_be;
    logic [PAD_W-1:0] hdr_pad;
    logic [6:0]       byte_off;
    logic [POS_W-1:0] bit_pos;

    // byte 0 moves to the top so a slice reads in network order
    always_comb begin
        for (int i = 0; i < HDR_W / 8; i++) begin
            hdr_be[HDR_W-1-8*i -: 8] = hdr_i[8*i +: 8];
        end
    end

    // zero tail keeps fields near the end in range
    assign hdr_pad  = {hdr_be, {(FW-8){1'b0}}};
    assign byte_off = action_i[12:6];
    assign bit_pos  = POS_W'(PAD_W - 1) - POS_W'({byte_off, 3'b000});

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            size_o <= parser_cfg_pkg::SZ_NONE;
            cont_o <= 3'd0;
        end else if (fire_i) begin
            size_o <= action_i[5:4];
            cont_o <= action_i[3:1];
        end
    end

    always_ff @(posedge axis_clk) begin
        if (fire_i) begin
            field_o <= hdr_pad[bit_pos -: FW];
        end
    end

endmodule

/* source/phv_builder.sv */
`timescale 1ns/1ps

module phv_builder #(
    parameter int HDR_W    = parser_cfg_pkg::HDR_W,
    parameter int ENTRY_W  = parser_cfg_pkg::ENTRY_W,
    parameter int ACT_W    = parser_cfg_pkg::ACT_W,
    parameter int NUM_ACT  = parser_cfg_pkg::NUM_ACT,
    parameter int NUM_CONT = parser_cfg_pkg::NUM_CONT,
    parameter int PHV_W    = parser_cfg_pkg::PHV_W
) (
    input  logic               axis_clk,
    input  logic               aresetn,
    input  logic               first_beat_i,
    input  logic [HDR_W-1:0]   hdr_i,
    input  logic [ENTRY_W-1:0] entry_i,
    output logic [PHV_W-1:0]   phv_o,
    output logic               phv_valid_o
);

    localparam int C2_W = parser_cfg_pkg::C2_W;
    localparam int C4_W = parser_cfg_pkg::C4_W;
    localparam int C6_W = parser_cfg_pkg::C6_W;

    localparam logic [1:0] ST_IDLE  = 2'd0;
    localparam logic [1:0] ST_WAIT1 = 2'd1;
    localparam logic [1:0] ST_WAIT2 = 2'd2;
    localparam logic [1:0] ST_GEN   = 2'd3;

    logic [1:0]      state;
    logic            fire;
    logic [C6_W-1:0] field [NUM_ACT];
    logic [1:0]      size  [NUM_ACT];
    logic [2:0]      cont  [NUM_ACT];
    logic [C6_W-1:0] cont_6b [NUM_CONT];
    logic [C4_W-1:0] cont_4b [NUM_CONT];
    logic [C2_W-1:0] cont_2b [NUM_CONT];

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            state       <= ST_IDLE;
            fire        <= 1'b0;
            phv_valid_o <= 1'b0;
        end else begin
            fire        <= (state == ST_WAIT1);
            phv_valid_o <= (state == ST_GEN);
            case (state)
                ST_IDLE:  if (first_beat_i) state <= ST_WAIT1;
                ST_WAIT1: state <= ST_WAIT2;
                ST_WAIT2: state <= ST_GEN;
                default:  state <= ST_IDLE;
            endcase
        end
    end

    // action 0 sits in the top bits of the entry
    for (genvar k = 0; k < NUM_ACT; k++) begin : g_ext
        field_extractor #(
            .HDR_W (HDR_W),
            .ACT_W (ACT_W)
        ) u_ext (
            .axis_clk (axis_clk),
            .aresetn  (aresetn),
            .fire_i   (fire),
            .hdr_i    (hdr_i),
            .action_i (entry_i[ENTRY_W-1-k*ACT_W -: ACT_W]),
            .field_o  (field[k]),
            .size_o   (size[k]),
            .cont_o   (cont[k])
        );
    end

    // later actions overwrite earlier ones on the same container
    always_ff @(posedge axis_clk) begin
        if (first_beat_i) begin
            for (int i = 0; i < NUM_CONT; i++) begin
                cont_6b[i] <= '0;
                cont_4b[i] <= '0;
                cont_2b[i] <= '0;
            end
        end else if (state == ST_GEN) begin
            for (int k = 0; k < NUM_ACT; k++) begin
                case (size[k])
                    parser_cfg_pkg::SZ_2B: cont_2b[cont[k]] <= field[k][C6_W-1 -: C2_W];
                    parser_cfg_pkg::SZ_4B: cont_4b[cont[k]] <= field[k][C6_W-1 -: C4_W];
                    parser_cfg_pkg::SZ_6B: cont_6b[cont[k]] <= field[k];
                    default: ;
                endcase
            end
        end
    end

    // 6B block on top, 2B container 0 in the lowest bits
    for (genvar i = 0; i < NUM_CONT; i++) begin : g_phv
        assign phv_o[i*C2_W +: C2_W] = cont_2b[i];
        assign phv_o[NUM_CONT*C2_W + i*C4_W +: C4_W] = cont_4b[i];
        assign phv_o[NUM_CONT*(C2_W+C4_W) + i*C6_W +: C6_W] = cont_6b[i];
    end

endmodule

/* source/ctrl_table_writer.sv */
`timescale 1ns/1ps

module ctrl_table_writer #(
    parameter int         DATA_W    = parser_cfg_pkg::DATA_W,
    parameter int         ENTRY_W   = parser_cfg_pkg::ENTRY_W,
    parameter int         TBL_AW    = parser_cfg_pkg::TBL_AW,
    parameter logic [2:0] PARSER_ID = 3'd0
) (
    input  logic               axis_clk,
    input  logic               aresetn,
    input  logic [DATA_W-1:0]  c_s_axis_tdata_i,
    input  logic               c_s_axis_tvalid_i,
    input  logic               c_s_axis_tlast_i,
    output logic               wr_en_o,
    output logic [TBL_AW-1:0]  wr_addr_o,
    output logic [ENTRY_W-1:0] wr_data_o,
    output logic [DATA_W-1:0]  c_m_axis_tdata_o,
    output logic               c_m_axis_tvalid_o,
    output logic               c_m_axis_tlast_o
);

    localparam logic ST_IDLE  = 1'b0;
    localparam logic ST_WRITE = 1'b1;

    logic                       state;
    logic [TBL_AW-1:0]          wr_idx;
    logic                       hdr_match;
    logic [ENTRY_W-1:0]         entry_swapped;
    parser_ctrl_pkg::ctrl_beat_u beat;

    assign beat = c_s_axis_tdata_i;

    assign hdr_match = c_s_axis_tvalid_i
                    && beat.hdr.mod_id[2:0] == PARSER_ID
                    && beat.hdr.flag == parser_ctrl_pkg::CTRL_FLAG;

    // first bytes of the beat become the top of the entry
    always_comb begin
        for (int j = 0; j < ENTRY_W / 8; j++) begin
            entry_swapped[ENTRY_W-1-8*j -: 8] = beat.bytes[j];
        end
    end

    always_ff @(posedge axis_clk or negedge aresetn) begin
        if (!aresetn) begin
            state             <= ST_IDLE;
            wr_idx            <= '0;
            wr_en_o           <= 1'b0;
            wr_addr_o         <= '0;
            c_m_axis_tdata_o  <= '0;
            c_m_axis_tvalid_o <= 1'b0;
            c_m_axis_tlast_o  <= 1'b0;
        end else begin
            wr_en_o <= 1'b0;
            if (state == ST_IDLE) begin
                if (hdr_match) begin
                    state             <= ST_WRITE;
                    wr_idx            <= beat.hdr.start_idx[TBL_AW-1:0];
                    c_m_axis_tdata_o  <= '0;
                    c_m_axis_tvalid_o <= 1'b0;
                    c_m_axis_tlast_o  <= 1'b0;
                end else begin
                    // pass through with one cycle delay
                    c_m_axis_tdata_o  <= c_s_axis_tdata_i;
                    c_m_axis_tvalid_o <= c_s_axis_tvalid_i;
                    c_m_axis_tlast_o  <= c_s_axis_tlast_i;
                end
            end else begin
                c_m_axis_tdata_o  <= '0;
                c_m_axis_tvalid_o <= 1'b0;
                c_m_axis_tlast_o  <= 1'b0;
                if (c_s_axis_tvalid_i && c_s_axis_tlast_i) begin
                    state <= ST_IDLE;
                end else if (c_s_axis_tvalid_i) begin
                    wr_en_o   <= 1'b1;
                    wr_addr_o <= wr_idx;
                    wr_idx    <= wr_idx + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge axis_clk) begin
        wr_data_o <= entry_swapped;
    end

endmodule

/* source/parser_top.sv */
`timescale 1ns/1ps

module parser_top #(
    parameter int         DATA_W    = parser_cfg_pkg::DATA_W,
    parameter int         HDR_W     = parser_cfg_pkg::HDR_W,
    parameter int         ACT_W     = parser_cfg_pkg::ACT_W,
    parameter int         NUM_ACT   = parser_cfg_pkg::NUM_ACT,
    parameter int         ENTRY_W   = parser_cfg_pkg::ENTRY_W,
    parameter int         TBL_AW    = parser_cfg_pkg::TBL_AW,
    parameter int         NUM_CONT  = parser_cfg_pkg::NUM_CONT,
    parameter int         PHV_W     = parser_cfg_pkg::PHV_W,
    parameter int         VLAN_LSB  = parser_cfg_pkg::VLAN_LSB,
    parameter logic [2:0] PARSER_ID = 3'd0
) (
    input  logic              axis_clk,
    input  logic              aresetn,
    input  logic [DATA_W-1:0] s_axis_tdata_i,
    input  logic              s_axis_tvalid_i,
    input  logic              s_axis_tlast_i,
    output logic [PHV_W-1:0]  phv_o,
    output logic              phv_valid_o,
    input  logic [DATA_W-1:0] c_s_axis_tdata_i,
    input  logic              c_s_axis_tvalid_i,
    input  logic              c_s_axis_tlast_i,
    output logic [DATA_W-1:0] c_m_axis_tdata_o,
    output logic              c_m_axis_tvalid_o,
    output logic              c_m_axis_tlast_o
);

    logic               first_beat;
    logic [HDR_W-1:0]   hdr;
    logic [TBL_AW-1:0]  rd_addr;
    logic [ENTRY_W-1:0] entry;
    logic               wr_en;
    logic [TBL_AW-1:0]  wr_addr;
    logic [ENTRY_W-1:0] wr_data;

    pkt_hdr_capture #(
        .DATA_W   (DATA_W),
        .HDR_W    (HDR_W),
        .TBL_AW   (TBL_AW),
        .VLAN_LSB (VLAN_LSB)
    ) u_capture (
        .axis_clk        (axis_clk),
        .aresetn         (aresetn),
        .s_axis_tdata_i  (s_axis_tdata_i),
        .s_axis_tvalid_i (s_axis_tvalid_i),
        .s_axis_tlast_i  (s_axis_tlast_i),
        .first_beat_o    (first_beat),
        .hdr_o           (hdr),
        .rd_addr_o       (rd_addr)
    );

    parse_act_ram #(
        .ENTRY_W (ENTRY_W),
        .TBL_AW  (TBL_AW)
    ) u_act_ram (
        .axis_clk  (axis_clk),
        .wr_en_i   (wr_en),
        .wr_addr_i (wr_addr),
        .wr_data_i (wr_data),
        .rd_addr_i (rd_addr),
        .entry_o   (entry)
    );

    phv_builder #(
        .HDR_W    (HDR_W),
        .ENTRY_W  (ENTRY_W),
        .ACT_W    (ACT_W),
        .NUM_ACT  (NUM_ACT),
        .NUM_CONT (NUM_CONT),
        .PHV_W    (PHV_W)
    ) u_builder (
        .axis_clk     (axis_clk),
        .aresetn      (aresetn),
        .first_beat_i (first_beat),
        .hdr_i        (hdr),
        .entry_i      (entry),
        .phv_o        (phv_o),
        .phv_valid_o  (phv_valid_o)
    );

    ctrl_table_writer #(
        .DATA_W    (DATA_W),
        .ENTRY_W   (ENTRY_W),
        .TBL_AW    (TBL_AW),
        .PARSER_ID (PARSER_ID)
    ) u_ctrl (
        .axis_clk          (axis_clk),
        .aresetn           (aresetn),
        .c_s_axis_tdata_i  (c_s_axis_tdata_i),
        .c_s_axis_tvalid_i (c_s_axis_tvalid_i),
        .c_s_axis_tlast_i  (c_s_axis_tlast_i),
        .wr_en_o           (wr_en),
        .wr_addr_o         (wr_addr),
        .wr_data_o         (wr_data),
        .c_m_axis_tdata_o  (c_m_axis_tdata_o),
        .c_m_axis_tvalid_o (c_m_axis_tvalid_o),
        .c_m_axis_tlast_o  (c_m_axis_tlast_o)
    );

endmodule

/* dv/parser_tb_cases.svh */
`ifndef PARSER_TB_CASES_SVH
`define PARSER_TB_CASES_SVH

// case kinds
localparam logic [1:0] K_WR  = 2'd0;
localparam logic [1:0] K_FWD = 2'd1;
localparam logic [1:0] K_PKT = 2'd2;

localparam int NUM_CASES = 16;
localparam int NUM_SETS  = 4;

localparam logic [1:0] SZ_0 = parser_cfg_pkg::SZ_NONE;
localparam logic [1:0] SZ_2 = parser_cfg_pkg::SZ_2B;
localparam logic [1:0] SZ_4 = parser_cfg_pkg::SZ_4B;
localparam logic [1:0] SZ_6 = parser_cfg_pkg::SZ_6B;

// idx is the start index of a table write, or the vlan id of a packet
// chg asks that the previous packet's entry would give this header another phv
typedef struct packed {
    logic [1:0]  kind;
    logic [7:0]  mod_id;
    logic [15:0] flag;
    logic [11:0] idx;
    logic [2:0]  cnt;
    logic [1:0]  aset;
    logic        last;
    logic        chg;
} case_t;

case_t       cases [NUM_CASES];
logic [15:0] act_set [NUM_SETS][NUM_ACT];

task automatic load_cases();
    // distinct containers, all three sizes, one field in the second beat
    act_set[0] = '{
        mk_act(0, SZ_6, 0),  mk_act(6, SZ_6, 1),  mk_act(12, SZ_2, 0), mk_act(14, SZ_2, 1),
        mk_act(26, SZ_4, 0), mk_act(30, SZ_4, 1), mk_act(34, SZ_2, 2), mk_act(36, SZ_2, 3),
        mk_act(60, SZ_4, 7), mk_act(64, SZ_6, 5)
    };
    // 4B container 3 and 2B container 4 targeted more than once
    act_set[1] = '{
        mk_act(2, SZ_4, 3),   mk_act(40, SZ_4, 3), mk_act(5, SZ_0, 0),  mk_act(70, SZ_2, 4),
        mk_act(100, SZ_6, 2), mk_act(90, SZ_2, 4), mk_act(11, SZ_0, 6), mk_act(50, SZ_4, 3),
        mk_act(8, SZ_6, 7),   mk_act(0, SZ_0, 0)
    };
    // end of the header window, the beat boundary, junk in the unused bits
    act_set[2] = '{
        mk_act(122, SZ_6, 6), mk_act(125, SZ_6, 3), mk_act(127, SZ_4, 5), mk_act(126, SZ_2, 6),
        mk_act(60, SZ_6, 4),  mk_act(62, SZ_4, 2),  mk_act(63, SZ_2, 7),
        mk_act(20, SZ_2, 5) | 16'he001,
        mk_act(3, SZ_0, 1),   mk_act(9, SZ_0, 2)
    };
    // every 6B container, action 8 overrides action 0
    act_set[3] = '{
        mk_act(1, SZ_6, 0),  mk_act(9, SZ_6, 1),  mk_act(17, SZ_6, 2), mk_act(25, SZ_6, 3),
        mk_act(33, SZ_6, 4), mk_act(41, SZ_6, 5), mk_act(49, SZ_6, 6), mk_act(57, SZ_6, 7),
        mk_act(3, SZ_6, 0),  mk_act(80, SZ_4, 6)
    };

    cases = '{
        '{K_WR,  8'h05, 16'hf2f1, 12'h002, 3'd3, 2'd0, 1'b0, 1'b0},
        '{K_PKT, 8'h00, 16'h0000, 12'h823, 3'd0, 2'd0, 1'b0, 1'b0},
        '{K_PKT, 8'h00, 16'h0000, 12'h135, 3'd0, 2'd0, 1'b0, 1'b1},
        '{K_PKT, 8'h00, 16'h0000, 12'h04a, 3'd0, 2'd0, 1'b0, 1'b1},
        '{K_FWD, 8'h06, 16'hf2f1, 12'h000, 3'd0, 2'd0, 1'b1, 1'b0},
        '{K_FWD, 8'h05, 16'hf2f0, 12'h000, 3'd0, 2'd0, 1'b0, 1'b0},
        '{K_FWD, 8'h03, 16'h1234, 12'h000, 3'd0, 2'd0, 1'b1, 1'b0},
        '{K_WR,  8'h1d, 16'hf2f1, 12'h008, 3'd2, 2'd3, 1'b0, 1'b0},
        '{K_PKT, 8'h00, 16'h0000, 12'h381, 3'd0, 2'd0, 1'b0, 1'b1},
        '{K_PKT, 8'h00, 16'h0000, 12'h092, 3'd0, 2'd0, 1'b0, 1'b1},
        '{K_PKT, 8'h00, 16'h0000, 12'hf3c, 3'd0, 2'd0, 1'b0, 1'b1},
        '{K_PKT, 8'h00, 16'h0000, 12'h020, 3'd0, 2'd0, 1'b0, 1'b1},
        '{K_FWD, 8'h05, 16'h0000, 12'h000, 3'd0, 2'd0, 1'b1, 1'b0},
        '{K_WR,  8'h05, 16'hf2f1, 12'h003, 3'd1, 2'd3, 1'b0, 1'b0},
        '{K_PKT, 8'h00, 16'h0000, 12'h730, 3'd0, 2'd0, 1'b0, 1'b1},
        '{K_PKT, 8'h00, 16'h0000, 12'h540, 3'd0, 2'd0, 1'b0, 1'b1}
    };
endtask

`endif

/* dv/parser_tb.sv */
`timescale 1ns/1ps

module parser_tb;

    localparam int         DATA_W    = parser_cfg_pkg::DATA_W;
    localparam int         HDR_W     = parser_cfg_pkg::HDR_W;
    localparam int         NUM_ACT   = parser_cfg_pkg::NUM_ACT;
    localparam int         NUM_CONT  = parser_cfg_pkg::NUM_CONT;
    localparam int         PHV_W     = parser_cfg_pkg::PHV_W;
    localparam logic [2:0] PARSER_ID = 3'd5;

    logic              axis_clk = 1'b0;
    logic              aresetn;
    logic [DATA_W-1:0] s_axis_tdata_i;
    logic              s_axis_tvalid_i;
    logic              s_axis_tlast_i;
    logic [PHV_W-1:0]  phv_o;
    logic              phv_valid_o;
    logic [DATA_W-1:0] c_s_axis_tdata_i;
    logic              c_s_axis_tvalid_i;
    logic              c_s_axis_tlast_i;
    logic [DATA_W-1:0] c_m_axis_tdata_o;
    logic              c_m_axis_tvalid_o;
    logic              c_m_axis_tlast_o;

    // copy of what the test has written into the action table
    logic [15:0]       shadow [16][NUM_ACT];
    logic [PHV_W-1:0]  last_phv;
    logic              have_prev;
    int                last_tbl;
    int                valid_cnt = 0;
    int                pkt_cnt;

    `include "parser_tb_cases.svh"

    parser_top #(
        .PARSER_ID (PARSER_ID)
    ) UUT (
        .axis_clk          (axis_clk),
        .aresetn           (aresetn),
        .s_axis_tdata_i    (s_axis_tdata_i),
        .s_axis_tvalid_i   (s_axis_tvalid_i),
        .s_axis_tlast_i    (s_axis_tlast_i),
        .phv_o             (phv_o),
        .phv_valid_o       (phv_valid_o),
        .c_s_axis_tdata_i  (c_s_axis_tdata_i),
        .c_s_axis_tvalid_i (c_s_axis_tvalid_i),
        .c_s_axis_tlast_i  (c_s_axis_tlast_i),
        .c_m_axis_tdata_o  (c_m_axis_tdata_o),
        .c_m_axis_tvalid_o (c_m_axis_tvalid_o),
        .c_m_axis_tlast_o  (c_m_axis_tlast_o)
    );

    always #5 axis_clk = ~axis_clk;

    always @(negedge axis_clk) begin
        if (phv_valid_o === 1'b1) begin
            valid_cnt <= valid_cnt + 1;
        end
    end

    initial begin
        repeat (NUM_CASES * 20 + 60) @(posedge axis_clk);
        $display("watchdog expired before all cases were applied");
        $display("Testbench failed");
        $fatal(1, "simulation timeout");
    end

    task automatic check_val(input string name, input logic [PHV_W-1:0] got,
                             input logic [PHV_W-1:0] exp);
        if (got !== exp) begin
            $display("ERR t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
            $display("Testbench failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    // action layout 12:6 offset, 5:4 size class, 3:1 container
    function automatic logic [15:0] mk_act(input int off, input logic [1:0] sz, input int cont);
        return {3'b000, off[6:0], sz, cont[2:0], 1'b0};
    endfunction

    function automatic logic [DATA_W-1:0] rand_beat();
        logic [DATA_W-1:0] b;
        for (int w = 0; w < DATA_W / 32; w++) begin
            b[32*w +: 32] = $urandom;
        end
        return b;
    endfunction

    function automatic logic [HDR_W-1:0] rand_header(input logic [11:0] vlan);
        logic [HDR_W-1:0] h;
        h = {rand_beat(), rand_beat()};
        h[parser_cfg_pkg::VLAN_LSB +: 12] = vlan;
        return h;
    endfunction

    function automatic logic [DATA_W-1:0] make_ctrl_hdr(input logic [7:0] mod_id,
                                                        input logic [15:0] flag,
                                                        input logic [7:0] start);
        logic [DATA_W-1:0] b;
        b = rand_beat();
        b[parser_ctrl_pkg::FLAG_LSB +: 16]  = flag;
        b[parser_ctrl_pkg::MOD_ID_LSB +: 8] = mod_id;
        b[parser_ctrl_pkg::IDX_LSB +: 8]    = start;
        return b;
    endfunction

    // bytes past the 128-byte window read as zero
    function automatic logic [7:0] hdr_byte(input logic [HDR_W-1:0] hdr, input int i);
        if (i < HDR_W / 8) begin
            return hdr[8*i +: 8];
        end
        return 8'h00;
    endfunction

    function automatic logic [PHV_W-1:0] model_phv(input logic [HDR_W-1:0] hdr, input int tbl);
        logic [47:0]      c6 [NUM_CONT];
        logic [31:0]      c4 [NUM_CONT];
        logic [15:0]      c2 [NUM_CONT];
        logic [47:0]      fld;
        logic [15:0]      act;
        logic [PHV_W-1:0] phv;
        int               off;
        int               cn;
        for (int i = 0; i < NUM_CONT; i++) begin
            c6[i] = '0;
            c4[i] = '0;
            c2[i] = '0;
        end
        // higher action index applied last
        for (int k = 0; k < NUM_ACT; k++) begin
            act = shadow[tbl][k];
            off = int'(act[12:6]);
            cn  = int'(act[3:1]);
            fld = '0;
            for (int b = 0; b < 6; b++) begin
                fld = {fld[39:0], hdr_byte(hdr, off + b)};
            end
            case (act[5:4])
                SZ_2: c2[cn] = fld[47:32];
                SZ_4: c4[cn] = fld[47:16];
                SZ_6: c6[cn] = fld;
                default: ;
            endcase
        end
        phv = '0;
        for (int i = NUM_CONT - 1; i >= 0; i--) begin
            phv = (phv << 48) | PHV_W'(c6[i]);
        end
        for (int i = NUM_CONT - 1; i >= 0; i--) begin
            phv = (phv << 32) | PHV_W'(c4[i]);
        end
        for (int i = NUM_CONT - 1; i >= 0; i--) begin
            phv = (phv << 16) | PHV_W'(c2[i]);
        end
        return phv;
    endfunction

    // one control beat during which nothing may be forwarded
    task automatic quiet_beat(input logic [DATA_W-1:0] data, input logic valid, input logic last);
        @(posedge axis_clk);
        c_s_axis_tdata_i  <= data;
        c_s_axis_tvalid_i <= valid;
        c_s_axis_tlast_i  <= last;
        @(negedge axis_clk);
        check_val("c_m_axis_tvalid_o", c_m_axis_tvalid_o, 1'b0);
    endtask

    task automatic write_table(input case_t cs);
        logic [DATA_W-1:0] beat;
        logic [15:0]       act;
        int                set_no;
        int                addr;
        quiet_beat(make_ctrl_hdr(cs.mod_id, cs.flag, cs.idx[7:0]), 1'b1, 1'b0);
        for (int i = 0; i < int'(cs.cnt); i++) begin
            set_no = (int'(cs.aset) + i) % NUM_SETS;
            addr   = (int'(cs.idx[3:0]) + i) % 16;
            beat   = rand_beat();
            // action k in bytes 2k and 2k+1, high byte first
            for (int k = 0; k < NUM_ACT; k++) begin
                act                 = act_set[set_no][k];
                beat[16*k +: 8]     = act[15:8];
                beat[16*k + 8 +: 8] = act[7:0];
                shadow[addr][k]     = act;
            end
            quiet_beat(beat, 1'b1, 1'b0);
        end
        quiet_beat(rand_beat(), 1'b1, 1'b1);
        quiet_beat(rand_beat(), 1'b0, 1'b0);
        quiet_beat(rand_beat(), 1'b0, 1'b0);
    endtask

    task automatic forward_beat(input case_t cs);
        logic [DATA_W-1:0] beat;
        beat = make_ctrl_hdr(cs.mod_id, cs.flag, 8'h00);
        @(posedge axis_clk);
        c_s_axis_tdata_i  <= beat;
        c_s_axis_tvalid_i <= 1'b1;
        c_s_axis_tlast_i  <= cs.last;
        @(negedge axis_clk);
        check_val("c_m_axis_tvalid_o", c_m_axis_tvalid_o, 1'b0);
        @(posedge axis_clk);
        c_s_axis_tvalid_i <= 1'b0;
        c_s_axis_tlast_i  <= 1'b0;
        @(negedge axis_clk);
        check_val("c_m_axis_tdata_o", c_m_axis_tdata_o, beat);
        check_val("c_m_axis_tvalid_o", c_m_axis_tvalid_o, 1'b1);
        check_val("c_m_axis_tlast_o", c_m_axis_tlast_o, cs.last);
        @(negedge axis_clk);
        check_val("c_m_axis_tvalid_o", c_m_axis_tvalid_o, 1'b0);
    endtask

    task automatic run_packet(input case_t cs);
        logic [HDR_W-1:0] hdr;
        logic [PHV_W-1:0] exp_phv;
        int               edge_no;
        hdr     = rand_header(cs.idx);
        exp_phv = model_phv(hdr, int'(cs.idx[7:4]));
        @(posedge axis_clk);
        s_axis_tdata_i  <= hdr[DATA_W-1:0];
        s_axis_tvalid_i <= 1'b1;
        s_axis_tlast_i  <= 1'b0;
        @(negedge axis_clk);
        if (have_prev) begin
            check_val("phv_o", phv_o, last_phv);
        end
        @(posedge axis_clk);
        s_axis_tdata_i  <= hdr[HDR_W-1 -: DATA_W];
        s_axis_tlast_i  <= 1'b1;
        @(posedge axis_clk);
        s_axis_tvalid_i <= 1'b0;
        s_axis_tlast_i  <= 1'b0;
        // edge 1 has sampled the second beat
        edge_no = 1;
        @(negedge axis_clk);
        while (phv_valid_o !== 1'b1) begin
            if (edge_no >= 20) begin
                $display("phv_valid_o never rose for the packet with vlan %0h", cs.idx);
                $display("Testbench failed");
                $fatal(1, "packet timeout");
            end
            @(posedge axis_clk);
            edge_no++;
            @(negedge axis_clk);
        end
        check_val("phv_valid_o edge", edge_no, 4);
        check_val("phv_o", phv_o, exp_phv);
        // the entry of the packet before must not give the same phv here
        if (cs.chg) begin
            check_val("phv_o vs previous entry", phv_o !== model_phv(hdr, last_tbl), 1'b1);
        end
        last_phv  = phv_o;
        last_tbl  = int'(cs.idx[7:4]);
        have_prev = 1'b1;
        pkt_cnt++;
    endtask

    initial begin
        void'($urandom(13));
        aresetn           = 1'b0;
        s_axis_tdata_i    = '0;
        s_axis_tvalid_i   = 1'b0;
        s_axis_tlast_i    = 1'b0;
        c_s_axis_tdata_i  = '0;
        c_s_axis_tvalid_i = 1'b0;
        c_s_axis_tlast_i  = 1'b0;
        have_prev         = 1'b0;
        last_phv          = '0;
        last_tbl          = 0;
        pkt_cnt           = 0;
        load_cases();
        repeat (8) @(posedge axis_clk);
        aresetn <= 1'b1;
        repeat (2) begin
            @(negedge axis_clk);
            check_val("phv_valid_o", phv_valid_o, 1'b0);
            check_val("c_m_axis_tvalid_o", c_m_axis_tvalid_o, 1'b0);
        end
        for (int i = 0; i < NUM_CASES; i++) begin
            case (cases[i].kind)
                K_WR:    write_table(cases[i]);
                K_FWD:   forward_beat(cases[i]);
                default: run_packet(cases[i]);
            endcase
        end
        repeat (6) @(posedge axis_clk);
        // one pulse per packet, never stretched
        check_val("phv_valid_o pulses", valid_cnt, pkt_cnt);
        $display("Testbench passed");
        $finish;
    end

endmodule

/* tb.f */
+incdir+dv
source/parser_cfg_pkg.sv
source/parser_ctrl_pkg.sv
source/pkt_hdr_capture.sv
source/parse_act_ram.sv
source/field_extractor.sv
source/phv_builder.sv
source/ctrl_table_writer.sv
source/parser_top.sv
dv/parser_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the parser testbench with verilator and run it
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module parser_tb \
    -f tb.f -o parser_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/parser_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation finished cleanly"
exit 0
